/* Bender.yml */
package:
  name: matrix_soc

sources:
  # package first, then the blocks, then the top level
  - matrix_pkg.sv
  - frame_buffer.sv
  - scan_timer.sv
  - scan_fsm.sv
  - status_display.sv
  - matrix_soc.sv

  - target: test
    files:
      - tb_matrix_soc.sv

/* compile.f */
matrix_pkg.sv
frame_buffer.sv
scan_timer.sv
scan_fsm.sv
status_display.sv
matrix_soc.sv
tb_matrix_soc.sv

/* frame_buffer.sv */
module frame_buffer
  import matrix_pkg::*;
(
  input  logic              clock_50,
  input  logic              arst_n,
  input  pixel_write_t      wr,
  input  logic              wr_valid,
  output logic              wr_ready,
  input  logic              rd_en,
  input  logic [pair_w-1:0] rd_pair,
  input  logic [col_w-1:0]  rd_col,
  output pixel_t            rd_upper,
  output pixel_t            rd_lower
);

  // bank 0 holds rows 0 to 7, bank 1 rows 8 to 15
  pixel_t bank_mem [2][bank_depth];

  logic                    bank_we;
  logic                    wr_bank;
  logic [pair_w+col_w-1:0] wr_addr;
  logic [pair_w+col_w-1:0] rd_addr;

  // the scanner owns both ports during scan_read
  // scan_fsm resets into scan_read, so ready stays low through reset as well
  assign wr_ready = !rd_en;

  assign bank_we = wr_valid && wr_ready;

  // row msb picks the half, the rest plus col is the word address
  assign wr_bank = wr.addr.row[row_w-1];
  assign wr_addr = {wr.addr.row[row_w-2:0], wr.addr.col};

  // same word address in both banks gives rows pair and pair + 8
  assign rd_addr = {rd_pair, rd_col};

  always_ff @(posedge clock_50) begin
    if (bank_we) begin
      bank_mem[wr_bank][wr_addr] <= wr.color;
    end
  end

  // read data comes out one cycle after rd_en
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      rd_upper <= '0;
      rd_lower <= '0;
    end else if (rd_en) begin
      rd_upper <= bank_mem[0][rd_addr];
      rd_lower <= bank_mem[1][rd_addr];
    end
  end

  // a write is refused while scanning and the port comes back the next cycle
  a_no_write_on_read: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    rd_en |-> !bank_we ##1 !rd_en
  );

endmodule

/* matrix_pkg.sv */
package matrix_pkg;

  // panel geometry
  localparam int panel_cols = 32;
  localparam int panel_rows = 16;
  localparam int row_pairs = panel_rows / 2;

  localparam int col_w = 5;
  localparam int row_w = 4;
  localparam int pair_w = 3;

  // one bank holds one half of the panel
  localparam int bank_depth = panel_cols * row_pairs;

  // cycles with oe_n low per row pair
  localparam int display_cycles = 64;
  localparam int dwell_w = $clog2(display_cycles + 1);

  // one bit per channel, red in the msb
  typedef logic [2:0] pixel_t;

  typedef struct packed {
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;
  } pixel_addr_t;

  typedef struct packed {
    pixel_addr_t addr;
    pixel_t      color;
  } pixel_write_t;

  // panel pins
  typedef struct packed {
    pixel_t            rgb0;
    pixel_t            rgb1;
    // drives a, b, c
    logic [pair_w-1:0] row_sel;
    logic              stb;
    logic              rgb_clk;
    logic              oe_n;
  } panel_t;

  // active-low segments, digit 0 is the rightmost
  typedef logic [5:0][6:0] hex_digits_t;

  typedef enum logic [2:0] {
    scan_read,
    scan_setup,
    scan_clock,
    scan_latch,
    scan_show
  } scan_state_e;

endpackage

/* matrix_soc.sv */
module matrix_soc
  import matrix_pkg::*;
(
  input  logic         clock_50,
  input  logic         arst_n,
  input  pixel_write_t pix_wr,
  input  logic         pix_wr_valid,
  output logic         pix_wr_ready,
  output panel_t       panel,
  output hex_digits_t  hex
);

  logic              rst_n;
  logic [2:0]        rst_sync;

  logic              rd_en;
  logic [pair_w-1:0] rd_pair;
  logic [col_w-1:0]  col;
  pixel_t            rd_upper;
  pixel_t            rd_lower;

  logic              col_clear;
  logic              col_step;
  logic              last_col;
  logic              dwell_start;
  logic              dwell_done;

  // reset asserts at once and releases after three edges
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= '0;
    end else begin
      rst_sync <= {rst_sync[1:0], 1'b1};
    end
  end

  assign rst_n = rst_sync[2];

  frame_buffer u_frame_buffer (
    .clock_50 (clock_50),
    .arst_n   (rst_n),
    .wr       (pix_wr),
    .wr_valid (pix_wr_valid),
    .wr_ready (pix_wr_ready),
    .rd_en    (rd_en),
    .rd_pair  (rd_pair),
    .rd_col   (col),
    .rd_upper (rd_upper),
    .rd_lower (rd_lower)
  );

  scan_timer u_scan_timer (
    .clock_50    (clock_50),
    .arst_n      (rst_n),
    .col_clear   (col_clear),
    .col_step    (col_step),
    .dwell_start (dwell_start),
    .col         (col),
    .last_col    (last_col),
    .dwell_done  (dwell_done)
  );

  scan_fsm u_scan_fsm (
    .clock_50    (clock_50),
    .arst_n      (rst_n),
    .last_col    (last_col),
    .dwell_done  (dwell_done),
    .rd_upper    (rd_upper),
    .rd_lower    (rd_lower),
    .col_clear   (col_clear),
    .col_step    (col_step),
    .dwell_start (dwell_start),
    .rd_en       (rd_en),
    .rd_pair     (rd_pair),
    .panel       (panel)
  );

  // status shows the last accepted pixel and the write count
  status_display u_status_display (
    .clock_50 (clock_50),
    .arst_n   (rst_n),
    .wr       (pix_wr),
    .wr_valid (pix_wr_valid),
    .wr_ready (pix_wr_ready),
    .hex      (hex)
  );

endmodule

/* scan_fsm.sv */
module scan_fsm
  import matrix_pkg::*;
(
  input  logic              clock_50,
  input  logic              arst_n,
  input  logic              last_col,
  input  logic              dwell_done,
  input  pixel_t            rd_upper,
  input  pixel_t            rd_lower,
  output logic              col_clear,
  output logic              col_step,
  output logic              dwell_start,
  output logic              rd_en,
  output logic [pair_w-1:0] rd_pair,
  output panel_t            panel
);

  scan_state_e state;
  scan_state_e state_next;

  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      state <= scan_read;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      scan_read:  state_next = scan_setup;
      scan_setup: state_next = scan_clock;
      scan_clock: state_next = last_col ? scan_latch : scan_read;
      scan_latch: state_next = scan_show;
      scan_show:  state_next = dwell_done ? scan_read : scan_show;
      default:    state_next = scan_read;
    endcase
  end

  // timer and buffer controls
  assign rd_en       = (state == scan_read);
  assign col_step    = (state == scan_clock) && !last_col;
  assign col_clear   = (state == scan_clock) && last_col;
  assign dwell_start = (state == scan_latch);

  // next row pair once the current one has been shown
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pair <= '0;
    end else if (state == scan_show && dwell_done) begin
      rd_pair <= rd_pair + 1'b1;
    end
  end

  // panel pins follow the state by one cycle
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      panel      <= '0;
      panel.oe_n <= 1'b1;
    end else begin
      panel.stb     <= 1'b0;
      panel.rgb_clk <= 1'b0;
      panel.oe_n    <= 1'b1;
      case (state)
        scan_setup: begin
          panel.rgb0 <= rd_upper;
          panel.rgb1 <= rd_lower;
        end
        scan_clock: begin
          panel.rgb_clk <= 1'b1;
        end
        scan_latch: begin
          panel.stb     <= 1'b1;
          panel.row_sel <= rd_pair;
        end
        scan_show: begin
          panel.oe_n <= 1'b0;
        end
        default: begin
          panel.oe_n <= 1'b1;
        end
      endcase
    end
  end

  // panel dark during the latch, lit right after it
  a_stb_blanked: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    panel.stb |-> panel.oe_n ##1 !panel.oe_n
  );

  // no shifting while a row is lit
  a_no_clk_when_lit: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    !(panel.rgb_clk && !panel.oe_n)
  );

endmodule

/* scan_timer.sv */
module scan_timer
  import matrix_pkg::*;
(
  input  logic             clock_50,
  input  logic             arst_n,
  input  logic             col_clear,
  input  logic             col_step,
  input  logic             dwell_start,
  output logic [col_w-1:0] col,
  output logic             last_col,
  output logic             dwell_done
);

  logic [dwell_w-1:0] dwell_cnt;

  // column counter
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      col <= '0;
    end else if (col_clear) begin
      col <= '0;
    end else if (col_step) begin
      col <= col + 1'b1;
    end
  end

  assign last_col = (col == col_w'(panel_cols - 1));

  // dwell down-counter, zero means idle
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      dwell_cnt <= '0;
    end else if (dwell_start) begin
      dwell_cnt <= dwell_w'(display_cycles);
    end else if (dwell_cnt != '0) begin
      dwell_cnt <= dwell_cnt - 1'b1;
    end
  end

  // high in the last of display_cycles counting cycles
  assign dwell_done = (dwell_cnt == dwell_w'(1));

  // done only ever follows a start, never an idle counter
  a_dwell_from_start: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    dwell_done |-> $past(dwell_start, display_cycles)
  );

endmodule

/* status_display.sv */
module status_display
  import matrix_pkg::*;
(
  input  logic         clock_50,
  input  logic         arst_n,
  input  pixel_write_t wr,
  input  logic         wr_valid,
  input  logic         wr_ready,
  output hex_digits_t  hex
);

  pixel_write_t last_wr;
  logic [7:0]   wr_count;

  // segments gfedcba, low is lit
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // last accepted write and an 8-bit accept count
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      last_wr  <= '0;
      wr_count <= '0;
    end else if (wr_valid && wr_ready) begin
      last_wr  <= wr;
      wr_count <= wr_count + 1'b1;
    end
  end

  assign hex[5] = seg7({3'b000, last_wr.addr.col[4]});
  assign hex[4] = seg7(last_wr.addr.col[3:0]);
  assign hex[3] = seg7(last_wr.addr.row);
  assign hex[2] = seg7({1'b0, last_wr.color});
  assign hex[1] = seg7(wr_count[7:4]);
  assign hex[0] = seg7(wr_count[3:0]);

endmodule

/* tb_matrix_soc.sv */
module tb_matrix_soc
  import matrix_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 4;
  localparam int reset_cycles = 5;
  localparam int pair_cycles = 3 * panel_cols + 1 + display_cycles;
  localparam int frame_cycles = row_pairs * pair_cycles;
  localparam int frame_pixels = panel_rows * panel_cols;
  localparam int random_writes = 400;
  // twenty frames of scanning plus margin
  localparam int watchdog_ns = 20 * frame_cycles * clk_period + 2000;

  logic         clock_50;
  logic         arst_n;
  pixel_write_t pix_wr;
  logic         pix_wr_valid;
  logic         pix_wr_ready;
  panel_t       panel;
  hex_digits_t  hex;

  // frame model and per-pair bookkeeping
  pixel_t               frame_model [panel_rows][panel_cols];
  bit                   known [panel_rows][panel_cols];
  bit                   dirty [row_pairs];
  int                   seed = 31;
  int                   writes_done = 0;
  pixel_write_t         last_write = '0;
  bit                   mon_en = 1'b0;
  bit                   quiet = 1'b0;
  bit                   pass_quiet = 1'b0;
  logic [row_pairs-1:0] quiet_pairs = '0;
  int                   quiet_pixels = 0;
  int                   mon_pair = 0;
  int                   rise_cnt = 0;
  int                   since_stb = 0;
  int                   low_run = 0;
  bit                   stb_seen = 1'b0;
  bit                   stb_prev = 1'b0;
  bit                   clk_prev = 1'b0;
  bit                   ready_seen = 1'b0;
  bit                   ready_low_prev = 1'b0;

  matrix_soc u_matrix_soc (
    .clock_50     (clock_50),
    .arst_n       (arst_n),
    .pix_wr       (pix_wr),
    .pix_wr_valid (pix_wr_valid),
    .pix_wr_ready (pix_wr_ready),
    .panel        (panel),
    .hex          (hex)
  );

  always #(clk_period / 2) clock_50 = ~clock_50;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_panel(input string name, input panel_t exp, input panel_t act,
                             input panel_t care);
    if ((act & care) !== (exp & care)) begin
      report_error($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name,
                             exp & care, act & care));
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      report_error($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_hex(input string name, input hex_digits_t exp, input hex_digits_t act);
    if (act !== exp) begin
      report_error($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_error($sformatf("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  // active-low gfedcba code of one hex digit
  function automatic logic [6:0] seg_code(input logic [3:0] nib);
    logic [6:0] code;
    case (nib)
      4'h0: code = 7'h40;
      4'h1: code = 7'h79;
      4'h2: code = 7'h24;
      4'h3: code = 7'h30;
      4'h4: code = 7'h19;
      4'h5: code = 7'h12;
      4'h6: code = 7'h02;
      4'h7: code = 7'h78;
      4'h8: code = 7'h00;
      4'h9: code = 7'h10;
      4'ha: code = 7'h08;
      4'hb: code = 7'h03;
      4'hc: code = 7'h46;
      4'hd: code = 7'h21;
      4'he: code = 7'h06;
      default: code = 7'h0e;
    endcase
    return code;
  endfunction

  function automatic hex_digits_t expected_hex(input pixel_write_t w, input int count);
    hex_digits_t h;
    logic [7:0]  cnt8;
    cnt8 = 8'(count % 256);
    h[5] = seg_code({3'b000, w.addr.col[4]});
    h[4] = seg_code(w.addr.col[3:0]);
    h[3] = seg_code(w.addr.row);
    h[2] = seg_code({1'b0, w.color});
    h[1] = seg_code(cnt8[7:4]);
    h[0] = seg_code(cnt8[3:0]);
    return h;
  endfunction

  task automatic check_reset_outputs();
    panel_t exp;
    panel_t care;
    exp = '0;
    exp.oe_n = 1'b1;
    care = '0;
    care.row_sel = '1;
    care.stb = 1'b1;
    care.rgb_clk = 1'b1;
    care.oe_n = 1'b1;
    check_panel("panel in reset", exp, panel, care);
    check_bit("pix_wr_ready in reset", 1'b0, pix_wr_ready);
    check_hex("hex in reset", expected_hex('0, 0), hex);
  endtask

  // model update one step after the accepting edge
  task automatic apply_write(input pixel_write_t w);
    frame_model[w.addr.row][w.addr.col] = w.color;
    known[w.addr.row][w.addr.col] = 1'b1;
    dirty[w.addr.row[pair_w-1:0]] = 1'b1;
    writes_done++;
    last_write = w;
    check_hex("hex after write", expected_hex(w, writes_done), hex);
  endtask

  task automatic send_write(input pixel_write_t w);
    int waited;
    waited = 0;
    pix_wr = w;
    pix_wr_valid = 1'b1;
    @(negedge clock_50);
    while (pix_wr_ready !== 1'b1) begin
      waited++;
      if (waited > 4) begin
        report_error("a pixel write was never accepted, pix_wr_ready stayed low");
      end
      @(negedge clock_50);
    end
    @(posedge clock_50);
    #1;
    pix_wr_valid = 1'b0;
    apply_write(w);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock_50);
      #1;
    end
  endtask

  task automatic fill_frame();
    pixel_write_t w;
    logic [31:0]  r;
    for (int row = 0; row < panel_rows; row++) begin
      for (int col = 0; col < panel_cols; col++) begin
        r = $random(seed);
        w.addr.row = row_w'(row);
        w.addr.col = col_w'(col);
        w.color = r[2:0];
        send_write(w);
      end
    end
  endtask

  task automatic random_write();
    pixel_write_t w;
    logic [31:0]  r;
    r = $random(seed);
    w = r[11:0];
    send_write(w);
  endtask

  task automatic compare_column(input int pair, input int col);
    int lower;
    lower = pair + row_pairs;
    if (known[pair][col] && known[lower][col]) begin
      check_pixel($sformatf("rgb0 row %0d col %0d", pair, col), frame_model[pair][col],
                  panel.rgb0);
      check_pixel($sformatf("rgb1 row %0d col %0d", lower, col), frame_model[lower][col],
                  panel.rgb1);
      if (pass_quiet && quiet_pairs != '1) begin
        quiet_pixels += 2;
      end
    end
  endtask

  // stb closes the pass of mon_pair
  task automatic end_of_pair();
    panel_t exp;
    panel_t care;
    exp = '0;
    exp.row_sel = pair_w'(mon_pair);
    exp.oe_n = 1'b1;
    care = '0;
    care.row_sel = '1;
    care.rgb_clk = 1'b1;
    care.oe_n = 1'b1;
    check_panel("panel at stb", exp, panel, care);
    check_count("rgb_clk rises per pair", panel_cols, rise_cnt);
    if (stb_seen) begin
      check_count("cycles per pair", pair_cycles, since_stb);
    end
    if (pass_quiet) begin
      quiet_pairs[mon_pair] = 1'b1;
    end
    stb_seen = 1'b1;
    since_stb = 0;
    rise_cnt = 0;
    mon_pair = (mon_pair + 1) % row_pairs;
    dirty[mon_pair] = 1'b0;
    pass_quiet = quiet;
  endtask

  // panel monitor, mid-cycle
  always @(negedge clock_50) begin
    if (mon_en) begin
      since_stb++;
      if (!pix_wr_ready && ready_low_prev && ready_seen) begin
        report_error("pix_wr_ready was low for two cycles in a row");
      end
      ready_seen = ready_seen || pix_wr_ready;
      ready_low_prev = !pix_wr_ready;
      // column index is the rise count within the pair
      if (panel.rgb_clk && !clk_prev) begin
        if (!dirty[mon_pair] && rise_cnt < panel_cols) begin
          compare_column(mon_pair, rise_cnt);
        end
        rise_cnt++;
      end
      if (stb_prev && panel.oe_n) begin
        report_error("oe_n did not go low right after stb");
      end
      if (!panel.oe_n) begin
        if (low_run == 0 && !stb_prev) begin
          report_error("oe_n went low without a preceding stb");
        end
        low_run++;
      end else if (low_run != 0) begin
        check_count("oe_n low cycles after stb", display_cycles, low_run);
        low_run = 0;
      end
      if (panel.stb) begin
        end_of_pair();
      end
      stb_prev = panel.stb;
      clk_prev = panel.rgb_clk;
    end
  end

  initial begin
    logic [31:0] r;
    clock_50 = 1'b0;
    arst_n = 1'b0;
    pix_wr = '0;
    pix_wr_valid = 1'b0;
    repeat (reset_cycles) begin
      @(negedge clock_50);
      check_reset_outputs();
    end
    @(posedge clock_50);
    #1;
    arst_n = 1'b1;
    mon_en = 1'b1;
    // synchronizer still holding the blocks in reset
    repeat (3) begin
      @(negedge clock_50);
      check_reset_outputs();
    end
    @(posedge clock_50);
    #1;
    fill_frame();
    while (writes_done < frame_pixels + random_writes) begin
      r = $random(seed);
      repeat (1 + r[2:0]) begin
        random_write();
      end
      idle_cycles(r[5:3] % 6);
    end
    quiet = 1'b1;
    wait (quiet_pairs == '1);
    check_count("pixels compared in quiet frame", frame_pixels, quiet_pixels);
    // display count must still match the writes sent
    check_hex("hex after quiet frame", expected_hex(last_write, writes_done), hex);
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    report_error("watchdog timeout, the test did not finish in the expected time");
  end

endmodule
